// ==== Bender.yml ====
package:
  name: cam_detect

sources:
  - common/cam_pkg.sv
  - common/bus_pkg.sv
  - common/pixel_if.sv
  - capture/ov7670_capture.sv
  - detect/target_finder.sv
  - detect/classification.sv
  - source/status_regs.sv
  - source/cam_detect_top.sv
  - target: test
    files:
      - verification/det_checker.sv
      - verification/tb_cam_detect.sv

// ==== capture/ov7670_capture.sv ====
`timescale 1ns/1ps

module ov7670_capture import cam_pkg::*; #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 480
) (
  input  logic       clk_25_vga,
  input  logic       rst_n,
  input  logic       vsync,
  input  logic       href,
  input  logic [7:0] d,
  pixel_if.src       pix_out
);

  // Last column and last row
  localparam logic [X_BITS-1:0] X_LAST = X_BITS'(FRAME_WIDTH - 1);
  localparam logic [Y_BITS-1:0] Y_LAST = Y_BITS'(FRAME_HEIGHT - 1);

  // High while the next byte is the second of a pair
  logic              byte_phase;
  logic              href_d;
  // Red nibble from the first byte
  chan_t             red_hold;
  // Coordinates of the pixel being assembled
  logic [X_BITS-1:0] x_cnt;
  logic [Y_BITS-1:0] y_cnt;
  logic              second_byte;
  logic              line_end;

  assign second_byte = href & byte_phase;
  // Falling edge of href closes a line
  assign line_end    = href_d & ~href;

  // Byte pairing and coordinate counters
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      byte_phase <= 1'b0;
      href_d     <= 1'b0;
      x_cnt      <= '0;
      y_cnt      <= '0;
    end else begin
      href_d <= href;
      // Pairing restarts with every line
      if (href) begin
        byte_phase <= ~byte_phase;
      end else begin
        byte_phase <= 1'b0;
      end
      if (vsync) begin
        // New frame
        x_cnt <= '0;
        y_cnt <= '0;
      end else if (line_end) begin
        x_cnt <= '0;
        y_cnt <= (y_cnt == Y_LAST) ? '0 : y_cnt + 1'b1;
      end else if (second_byte) begin
        x_cnt <= (x_cnt == X_LAST) ? '0 : x_cnt + 1'b1;
      end
    end
  end

  // First byte, xxxxRRRR
  always_ff @(posedge clk_25_vga) begin
    if (href && !byte_phase) begin
      red_hold <= d[3:0];
    end
  end

  // Output beat control
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      pix_out.valid <= 1'b0;
      pix_out.last  <= 1'b0;
    end else begin
      pix_out.valid <= second_byte;
      pix_out.last  <= second_byte && (x_cnt == X_LAST) && (y_cnt == Y_LAST);
    end
  end

  // Second byte, GGGGBBBB
  always_ff @(posedge clk_25_vga) begin
    if (second_byte) begin
      pix_out.pix <= '{red: red_hold, green: d[7:4], blue: d[3:0]};
      pix_out.x   <= x_cnt;
      pix_out.y   <= y_cnt;
    end
  end

endmodule

// ==== common/bus_pkg.sv ====
package bus_pkg;

  // Wishbone widths
  localparam int WB_ADDR_BITS = 3;
  localparam int WB_DATA_BITS = 32;

  // Register word addresses
  localparam logic [WB_ADDR_BITS-1:0] REG_THRESH       = 3'd0;
  localparam logic [WB_ADDR_BITS-1:0] REG_MIN_COUNT    = 3'd1;
  localparam logic [WB_ADDR_BITS-1:0] REG_STATUS       = 3'd2;
  localparam logic [WB_ADDR_BITS-1:0] REG_ORANGE_COUNT = 3'd3;
  localparam logic [WB_ADDR_BITS-1:0] REG_FRAME_COUNT  = 3'd4;

  // Threshold defaults, a bright saturated orange
  localparam logic [3:0]  RED_MIN_RST   = 4'd12;
  localparam logic [3:0]  GREEN_MAX_RST = 4'd9;
  localparam logic [3:0]  BLUE_MAX_RST  = 4'd4;
  localparam logic [15:0] MIN_COUNT_RST = 16'd16;

  // Same bit layout as REG_THRESH, red_min in the low nibble
  typedef struct packed {
    logic [3:0] blue_max;
    logic [3:0] green_max;
    logic [3:0] red_min;
  } thresh_t;

endpackage

// ==== common/cam_pkg.sv ====
package cam_pkg;

  // Coordinate widths, enough for 640x480
  localparam int X_BITS = 10;
  localparam int Y_BITS = 10;

  // One RGB444 colour channel
  typedef logic [3:0] chan_t;

  // Pixel as assembled from the camera byte pair
  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } pixel_t;

  // Band where the target was seen
  typedef enum logic [1:0] {
    DIR_NONE   = 2'd0,
    DIR_LEFT   = 2'd1,
    DIR_CENTER = 2'd2,
    DIR_RIGHT  = 2'd3
  } direction_t;

  // Orange pixels are painted white on the output stream
  localparam pixel_t HIGHLIGHT = '{
    red:   4'hf,
    green: 4'hf,
    blue:  4'hf
  };

endpackage

// ==== common/pixel_if.sv ====
`timescale 1ns/1ps

interface pixel_if import cam_pkg::*; ();

  // Beat qualifier, no back-pressure
  logic              valid;
  pixel_t            pix;
  logic [X_BITS-1:0] x;
  logic [Y_BITS-1:0] y;
  // Final pixel of the frame
  logic              last;

  modport src (
    output valid,
    output pix,
    output x,
    output y,
    output last
  );

  modport snk (
    input valid,
    input pix,
    input x,
    input y,
    input last
  );

endinterface

// ==== detect/classification.sv ====
`timescale 1ns/1ps

module classification import cam_pkg::*; #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 480
) (
  input  logic        clk_25_vga,
  input  logic        rst_n,
  pixel_if.snk        pix_in,
  input  logic        is_orange,
  input  logic [15:0] min_count,
  output logic        frame_done,
  output logic        detected,
  output direction_t  direction,
  output logic [15:0] orange_count
);

  // Counters hold a full frame, at least 16 bits
  localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int PIX_BITS     = $clog2(FRAME_PIXELS + 1);
  localparam int CNT_BITS     = (PIX_BITS > 16) ? PIX_BITS : 16;
  // Band edges
  localparam logic [X_BITS-1:0] LEFT_END    = X_BITS'(FRAME_WIDTH / 3);
  localparam logic [X_BITS-1:0] RIGHT_START = X_BITS'((2 * FRAME_WIDTH) / 3);
  // Largest count the 16-bit result can show
  localparam logic [CNT_BITS-1:0] COUNT_MAX = CNT_BITS'(16'hffff);

  logic [CNT_BITS-1:0] cnt_left;
  logic [CNT_BITS-1:0] cnt_center;
  logic [CNT_BITS-1:0] cnt_right;
  logic [CNT_BITS-1:0] next_left;
  logic [CNT_BITS-1:0] next_center;
  logic [CNT_BITS-1:0] next_right;
  logic [CNT_BITS-1:0] total;
  logic                hit;
  logic                in_left;
  logic                in_right;
  logic                frame_end;
  direction_t          winner;

  assign hit       = pix_in.valid & is_orange;
  assign in_left   = pix_in.x < LEFT_END;
  assign in_right  = pix_in.x >= RIGHT_START;
  assign frame_end = pix_in.valid & pix_in.last;

  // Counts including the current beat
  always_comb begin
    next_left   = cnt_left + CNT_BITS'(hit & in_left);
    next_center = cnt_center + CNT_BITS'(hit & ~in_left & ~in_right);
    next_right  = cnt_right + CNT_BITS'(hit & in_right);
    total       = next_left + next_center + next_right;
  end

  // Largest band, ties favour centre then left
  always_comb begin
    if (next_center >= next_left && next_center >= next_right) begin
      winner = DIR_CENTER;
    end else if (next_left >= next_right) begin
      winner = DIR_LEFT;
    end else begin
      winner = DIR_RIGHT;
    end
  end

  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      cnt_left     <= '0;
      cnt_center   <= '0;
      cnt_right    <= '0;
      frame_done   <= 1'b0;
      detected     <= 1'b0;
      direction    <= DIR_NONE;
      orange_count <= '0;
    end else begin
      frame_done <= frame_end;
      if (frame_end) begin
        // Latch the frame result and start over
        cnt_left     <= '0;
        cnt_center   <= '0;
        cnt_right    <= '0;
        orange_count <= (total > COUNT_MAX) ? 16'hffff : total[15:0];
        if (total < CNT_BITS'(min_count)) begin
          detected  <= 1'b0;
          direction <= DIR_NONE;
        end else begin
          detected  <= 1'b1;
          direction <= winner;
        end
      end else if (pix_in.valid) begin
        cnt_left   <= next_left;
        cnt_center <= next_center;
        cnt_right  <= next_right;
      end
    end
  end

endmodule

// ==== detect/target_finder.sv ====
`timescale 1ns/1ps

module target_finder import cam_pkg::*, bus_pkg::*; (
  input  logic    clk_25_vga,
  input  logic    rst_n,
  input  thresh_t thresh,
  pixel_if.snk    pix_in,
  pixel_if.src    pix_out,
  output logic    is_orange
);

  logic red_ok;
  logic green_ok;
  logic blue_ok;
  logic red_over_green;
  logic match;

  // Orange rule on the incoming pixel
  assign red_ok         = pix_in.pix.red >= thresh.red_min;
  assign green_ok       = pix_in.pix.green <= thresh.green_max;
  assign blue_ok        = pix_in.pix.blue <= thresh.blue_max;
  // Strictly redder than green, so grey and yellow fail
  assign red_over_green = pix_in.pix.red > pix_in.pix.green;
  assign match          = red_ok & green_ok & blue_ok & red_over_green;

  // Beat control and the orange flag
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      pix_out.valid <= 1'b0;
      pix_out.last  <= 1'b0;
      is_orange     <= 1'b0;
    end else begin
      pix_out.valid <= pix_in.valid;
      pix_out.last  <= pix_in.valid & pix_in.last;
      // Flag only on real beats
      is_orange     <= pix_in.valid & match;
    end
  end

  // Payload, matches painted white
  always_ff @(posedge clk_25_vga) begin
    if (pix_in.valid) begin
      pix_out.pix <= match ? HIGHLIGHT : pix_in.pix;
      pix_out.x   <= pix_in.x;
      pix_out.y   <= pix_in.y;
    end
  end

endmodule

// ==== list.f ====
common/cam_pkg.sv
common/bus_pkg.sv
common/pixel_if.sv
capture/ov7670_capture.sv
detect/target_finder.sv
detect/classification.sv
source/status_regs.sv
source/cam_detect_top.sv
verification/det_checker.sv
verification/tb_cam_detect.sv

// ==== source/cam_detect_top.sv ====
`timescale 1ns/1ps

module cam_detect_top import cam_pkg::*, bus_pkg::*; #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 480
) (
  input  logic                    clk_25_vga,
  input  logic                    rst_n,
  // Camera pins
  input  logic                    cam_vsync,
  input  logic                    cam_href,
  input  logic [7:0]              cam_d,
  // Host register bus
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [WB_ADDR_BITS-1:0] wb_adr,
  input  logic [WB_DATA_BITS-1:0] wb_dat_w,
  output logic [WB_DATA_BITS-1:0] wb_dat_r,
  output logic                    wb_ack,
  // Highlighted pixel stream
  output logic                    out_valid,
  output pixel_t                  out_pix,
  output logic [X_BITS-1:0]       out_x,
  output logic [Y_BITS-1:0]       out_y,
  output logic                    out_orange,
  // Frame result
  output logic                    target_detected,
  output direction_t              target_direction
);

  pixel_if cap_if ();
  pixel_if fin_if ();

  thresh_t     thresh;
  logic [15:0] min_count;
  logic        frame_done;
  logic [15:0] orange_count;

  // Camera bytes to pixels
  ov7670_capture #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) u_capture (
    .clk_25_vga(clk_25_vga),
    .rst_n     (rst_n),
    .vsync     (cam_vsync),
    .href      (cam_href),
    .d         (cam_d),
    .pix_out   (cap_if.src)
  );

  target_finder u_finder (
    .clk_25_vga(clk_25_vga),
    .rst_n     (rst_n),
    .thresh    (thresh),
    .pix_in    (cap_if.snk),
    .pix_out   (fin_if.src),
    .is_orange (out_orange)
  );

  // Band counts per frame
  classification #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) u_classifier (
    .clk_25_vga  (clk_25_vga),
    .rst_n       (rst_n),
    .pix_in      (fin_if.snk),
    .is_orange   (out_orange),
    .min_count   (min_count),
    .frame_done  (frame_done),
    .detected    (target_detected),
    .direction   (target_direction),
    .orange_count(orange_count)
  );

  status_regs u_regs (
    .clk_25_vga  (clk_25_vga),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .frame_done  (frame_done),
    .detected    (target_detected),
    .direction   (target_direction),
    .orange_count(orange_count),
    .thresh      (thresh),
    .min_count   (min_count)
  );

  // Finder output to the pins
  assign out_valid = fin_if.valid;
  assign out_pix   = fin_if.pix;
  assign out_x     = fin_if.x;
  assign out_y     = fin_if.y;

endmodule

// ==== source/status_regs.sv ====
`timescale 1ns/1ps

module status_regs import cam_pkg::*, bus_pkg::*; (
  input  logic                    clk_25_vga,
  input  logic                    rst_n,
  // Wishbone classic slave
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [WB_ADDR_BITS-1:0] wb_adr,
  input  logic [WB_DATA_BITS-1:0] wb_dat_w,
  output logic [WB_DATA_BITS-1:0] wb_dat_r,
  output logic                    wb_ack,
  // Frame results
  input  logic                    frame_done,
  input  logic                    detected,
  input  direction_t              direction,
  input  logic [15:0]             orange_count,
  // Settings to the pixel path
  output thresh_t                 thresh,
  output logic [15:0]             min_count
);

  logic                    req;
  logic                    access;
  logic [15:0]             frame_count;
  logic [WB_DATA_BITS-1:0] rd_data;

  assign req    = wb_cyc & wb_stb;
  // First cycle of a request, ack follows
  assign access = req & ~wb_ack;

  // Single-cycle ack
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
    end
  end

  // Writable registers and the frame counter
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      thresh      <= '{blue_max: BLUE_MAX_RST, green_max: GREEN_MAX_RST,
                       red_min: RED_MIN_RST};
      min_count   <= MIN_COUNT_RST;
      frame_count <= '0;
    end else begin
      if (access && wb_we) begin
        case (wb_adr)
          REG_THRESH:    thresh    <= thresh_t'(wb_dat_w[11:0]);
          REG_MIN_COUNT: min_count <= wb_dat_w[15:0];
          // Status and counts are read only
          default: ;
        endcase
      end
      if (frame_done) begin
        frame_count <= frame_count + 1'b1;
      end
    end
  end

  // Read mux, unmapped reads as zero
  always_comb begin
    rd_data = '0;
    case (wb_adr)
      REG_THRESH:       rd_data[11:0] = thresh;
      REG_MIN_COUNT:    rd_data[15:0] = min_count;
      REG_STATUS:       rd_data[2:0]  = {direction, detected};
      REG_ORANGE_COUNT: rd_data[15:0] = orange_count;
      REG_FRAME_COUNT:  rd_data[15:0] = frame_count;
      default:          rd_data       = '0;
    endcase
  end

  // Read data held for the ack cycle
  always_ff @(posedge clk_25_vga) begin
    if (access) begin
      wb_dat_r <= wb_we ? '0 : rd_data;
    end
  end

endmodule

// ==== verification/det_checker.sv ====
`timescale 1ns/1ps

module det_checker import cam_pkg::*, bus_pkg::*; #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 480
) (
  input logic                    clk_25_vga,
  input logic                    rst_n,
  input logic                    cam_vsync,
  input logic                    cam_href,
  input logic [7:0]              cam_d,
  input logic                    wb_ack,
  input logic                    wb_we,
  input logic [WB_ADDR_BITS-1:0] wb_adr,
  input logic [WB_DATA_BITS-1:0] wb_dat_w,
  input logic [WB_DATA_BITS-1:0] wb_dat_r,
  input logic                    out_valid,
  input pixel_t                  out_pix,
  input logic [X_BITS-1:0]       out_x,
  input logic [Y_BITS-1:0]       out_y,
  input logic                    out_orange,
  input logic                    target_detected,
  input direction_t              target_direction
);

  // Expected output beats, oldest first
  pixel_t            exp_pix[$];
  logic [X_BITS-1:0] exp_x[$];
  logic [Y_BITS-1:0] exp_y[$];
  int unsigned       exp_due[$];

  // Camera side of the model
  int unsigned cycle = 0;
  bit          phase;
  bit          href_q;
  logic [3:0]  red_q;
  int          mx;
  int          my;
  // Register file as the host should see it
  logic [3:0]  m_red_min;
  logic [3:0]  m_green_max;
  logic [3:0]  m_blue_max;
  logic [15:0] m_min_count;
  logic [15:0] m_orange;
  logic [15:0] m_frames;
  bit          m_detected;
  direction_t  m_dir;
  // Band counts of the frame in flight
  int          c_left;
  int          c_center;
  int          c_right;
  int unsigned result_due;
  bit          ack_q;
  // Scoreboard
  int          error_count = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  // Orange when all four conditions hold
  function automatic bit rule_orange(input pixel_t p);
    return (p.red >= m_red_min) && (p.green <= m_green_max) &&
           (p.blue <= m_blue_max) && (p.red > p.green);
  endfunction

  function automatic logic [31:0] reg_value(input logic [WB_ADDR_BITS-1:0] adr);
    logic [31:0] v;
    v = '0;
    case (adr)
      REG_THRESH:       v[11:0] = {m_blue_max, m_green_max, m_red_min};
      REG_MIN_COUNT:    v[15:0] = m_min_count;
      REG_STATUS:       v[2:0]  = {m_dir, m_detected};
      REG_ORANGE_COUNT: v[15:0] = m_orange;
      REG_FRAME_COUNT:  v[15:0] = m_frames;
      default:          v       = '0;
    endcase
    return v;
  endfunction

  task automatic reset_model();
    exp_pix.delete();
    exp_x.delete();
    exp_y.delete();
    exp_due.delete();
    phase       = 0;
    href_q      = 0;
    mx          = 0;
    my          = 0;
    m_red_min   = RED_MIN_RST;
    m_green_max = GREEN_MAX_RST;
    m_blue_max  = BLUE_MAX_RST;
    m_min_count = MIN_COUNT_RST;
    m_orange    = '0;
    m_frames    = '0;
    m_detected  = 0;
    m_dir       = DIR_NONE;
    c_left      = 0;
    c_center    = 0;
    c_right     = 0;
    result_due  = 0;
    ack_q       = 0;
  endtask

  // Host accesses, judged on the ack cycle
  task automatic watch_bus();
    logic [31:0] want;
    if (wb_ack) begin
      if (ack_q) begin
        report_mismatch("wb_ack high for more than one cycle");
      end
      if (wb_we) begin
        if (wb_adr == REG_THRESH) begin
          m_red_min   = wb_dat_w[3:0];
          m_green_max = wb_dat_w[7:4];
          m_blue_max  = wb_dat_w[11:8];
        end else if (wb_adr == REG_MIN_COUNT) begin
          m_min_count = wb_dat_w[15:0];
        end
      end else begin
        want = reg_value(wb_adr);
        if (wb_dat_r !== want) begin
          report_mismatch($sformatf("read of address %0d got %h expected %h",
                                    wb_adr, wb_dat_r, want));
        end
      end
    end
    ack_q = wb_ack;
  endtask

  // Frame result from the band counts
  task automatic close_frame();
    int total;
    total    = c_left + c_center + c_right;
    m_orange = (total > 65535) ? 16'hffff : 16'(total);
    if (total < m_min_count) begin
      m_detected = 0;
      m_dir      = DIR_NONE;
    end else begin
      m_detected = 1;
      if (c_center >= c_left && c_center >= c_right) m_dir = DIR_CENTER;
      else if (c_left >= c_right) m_dir = DIR_LEFT;
      else m_dir = DIR_RIGHT;
    end
    m_frames   = m_frames + 1'b1;
    result_due = cycle + 1;
    c_left     = 0;
    c_center   = 0;
    c_right    = 0;
  endtask

  task automatic watch_output();
    pixel_t            p;
    pixel_t            want;
    logic [X_BITS-1:0] x;
    logic [Y_BITS-1:0] y;
    int unsigned       due;
    bit                orange;
    if (out_valid) begin
      if (exp_pix.size() == 0) begin
        report_mismatch("output beat with no camera pixel behind it");
      end else begin
        p      = exp_pix.pop_front();
        x      = exp_x.pop_front();
        y      = exp_y.pop_front();
        due    = exp_due.pop_front();
        orange = rule_orange(p);
        want   = orange ? HIGHLIGHT : p;
        if (due != cycle)
          report_mismatch($sformatf("beat at (%0d,%0d) %0d cycles late", x, y, cycle - due));
        if (out_pix !== want)
          report_mismatch($sformatf("out_pix got %h expected %h", out_pix, want));
        if (out_x !== x || out_y !== y)
          report_mismatch($sformatf("coords got (%0d,%0d) expected (%0d,%0d)",
                                    out_x, out_y, x, y));
        if (out_orange !== orange)
          report_mismatch($sformatf("out_orange got %b for pixel %h", out_orange, p));
        if (orange) begin
          if (x < FRAME_WIDTH / 3) c_left++;
          else if (x >= (2 * FRAME_WIDTH) / 3) c_right++;
          else c_center++;
        end
        if (x == FRAME_WIDTH - 1 && y == FRAME_HEIGHT - 1) close_frame();
      end
    end else if (exp_due.size() > 0 && exp_due[0] <= cycle) begin
      report_mismatch($sformatf("no beat for pixel (%0d,%0d)", exp_x[0], exp_y[0]));
      void'(exp_pix.pop_front());
      void'(exp_x.pop_front());
      void'(exp_y.pop_front());
      void'(exp_due.pop_front());
    end
  endtask

  // Result pins one cycle after the last beat
  task automatic watch_result();
    if (result_due != 0 && cycle == result_due) begin
      if (target_detected !== m_detected || target_direction !== m_dir)
        report_mismatch($sformatf("result got %b/%s expected %b/%s", target_detected,
                                  target_direction.name(), m_detected, m_dir.name()));
      result_due = 0;
    end
  endtask

  // Byte pairing and coordinates from the camera pins
  task automatic watch_camera();
    if (cam_vsync) begin
      mx = 0;
      my = 0;
    end else if (href_q && !cam_href) begin
      mx = 0;
      my = (my == FRAME_HEIGHT - 1) ? 0 : my + 1;
    end
    if (cam_href && !phase) begin
      red_q = cam_d[3:0];
      phase = 1;
    end else if (cam_href) begin
      exp_pix.push_back(pixel_t'({red_q, cam_d}));
      exp_x.push_back(X_BITS'(mx));
      exp_y.push_back(Y_BITS'(my));
      exp_due.push_back(cycle + 2);
      mx    = (mx == FRAME_WIDTH - 1) ? 0 : mx + 1;
      phase = 0;
    end else begin
      phase = 0;
    end
    href_q = cam_href;
  endtask

  always @(posedge clk_25_vga) begin
    cycle = cycle + 1;
    if (!rst_n) begin
      reset_model();
    end else begin
      watch_bus();
      watch_output();
      watch_result();
      watch_camera();
    end
  end

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d, %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d, %s: failed with %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
  endtask

endmodule

// ==== verification/tb_cam_detect.sv ====
`timescale 1ns/1ps

module tb_cam_detect import cam_pkg::*, bus_pkg::*; ();

  localparam int W = 24;
  localparam int H = 6;
  // Pixel patterns of a frame
  localparam int MODE_RANDOM  = 0;
  localparam int MODE_LEFT    = 1;
  localparam int MODE_CENTER  = 2;
  localparam int MODE_RIGHT   = 3;
  localparam int MODE_TIE_LR  = 4;
  localparam int MODE_TIE_ALL = 5;
  localparam int MODE_SPARSE  = 6;

  logic                    clk_25_vga = 1'b0;
  logic                    rst_n;
  logic                    cam_vsync;
  logic                    cam_href;
  logic [7:0]              cam_d;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [WB_ADDR_BITS-1:0] wb_adr;
  logic [WB_DATA_BITS-1:0] wb_dat_w;
  logic [WB_DATA_BITS-1:0] wb_dat_r;
  logic                    wb_ack;
  logic                    out_valid;
  pixel_t                  out_pix;
  logic [X_BITS-1:0]       out_x;
  logic [Y_BITS-1:0]       out_y;
  logic                    out_orange;
  logic                    target_detected;
  direction_t              target_direction;
  logic [31:0]             rng_state = 32'd76218;

  always #10 clk_25_vga = ~clk_25_vga;

  cam_detect_top #(.FRAME_WIDTH(W), .FRAME_HEIGHT(H)) dut0 (
    .clk_25_vga(clk_25_vga), .rst_n(rst_n),
    .cam_vsync(cam_vsync), .cam_href(cam_href), .cam_d(cam_d),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .out_valid(out_valid), .out_pix(out_pix), .out_x(out_x), .out_y(out_y),
    .out_orange(out_orange), .target_detected(target_detected),
    .target_direction(target_direction)
  );

  det_checker #(.FRAME_WIDTH(W), .FRAME_HEIGHT(H)) det_chk (
    .clk_25_vga(clk_25_vga), .rst_n(rst_n),
    .cam_vsync(cam_vsync), .cam_href(cam_href), .cam_d(cam_d),
    .wb_ack(wb_ack), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
    .out_valid(out_valid), .out_pix(out_pix), .out_x(out_x), .out_y(out_y),
    .out_orange(out_orange), .target_detected(target_detected),
    .target_direction(target_direction)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Picks orange or background per pattern and band
  function automatic logic [11:0] make_pixel(input int mode, input int x, input int y);
    logic [31:0] r;
    int          band;
    bit          hit;
    logic [11:0] p;
    r    = next_random();
    band = (x < W / 3) ? 0 : ((x >= (2 * W) / 3) ? 2 : 1);
    case (mode)
      MODE_LEFT, MODE_CENTER, MODE_RIGHT:
        hit = (band == mode - MODE_LEFT) ? (r[15:14] != 0) : (r[17:15] == 0);
      MODE_TIE_LR:  hit = (band != 1) && (x % 8 < 3);
      MODE_TIE_ALL: hit = (x % 8 < 3);
      MODE_SPARSE:  hit = (y == 0) && (x < 4);
      default:      hit = 0;
    endcase
    if (mode == MODE_RANDOM) begin
      p = r[11:0];
      // Red equal to green on about a quarter of the pixels
      if (r[13:12] == 0) p[7:4] = p[11:8];
    end else if (hit) begin
      p = {2'b11, r[21:20], 4'(r[25:22] % 10), 4'(r[29:27] % 5)};
    end else begin
      p = {1'b0, r[20:18], r[25:22], r[29:26]};
    end
    return p;
  endfunction

  task automatic end_run(input bit timed_out);
    det_chk.report_counts();
    if (!timed_out && det_chk.error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] data);
    int waited;
    bit got;
    got = 0;
    @(posedge clk_25_vga);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    for (waited = 0; waited < 16 && !got; waited++) begin
      @(posedge clk_25_vga);
      got = wb_ack;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!got) begin
      $display("Timeout: no Wishbone ack within 16 cycles at address %0d", adr);
      end_run(1'b1);
    end
  endtask

  task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
    bus_access(1'b1, adr, data);
  endtask

  // Read data is judged by the checker
  task automatic bus_read(input logic [2:0] adr);
    bus_access(1'b0, adr, 32'h0);
  endtask

  task automatic restore_defaults();
    bus_write(REG_THRESH, {20'h0, BLUE_MAX_RST, GREEN_MAX_RST, RED_MIN_RST});
    bus_write(REG_MIN_COUNT, {16'h0, MIN_COUNT_RST});
  endtask

  // Waits for the last beat of the frame and one more cycle for the result
  task automatic wait_frame_end();
    int waited;
    bit got;
    got = 0;
    for (waited = 0; waited < 16 && !got; waited++) begin
      @(posedge clk_25_vga);
      got = out_valid && out_x == X_BITS'(W - 1) && out_y == Y_BITS'(H - 1);
    end
    if (!got) begin
      $display("Timeout: the last pixel of the frame never left the DUT");
      end_run(1'b1);
    end
    @(posedge clk_25_vga);
  endtask

  task automatic send_frame(input int mode);
    logic [11:0] p;
    logic [31:0] r;
    @(posedge clk_25_vga);
    cam_vsync <= 1'b1;
    repeat (2) @(posedge clk_25_vga);
    cam_vsync <= 1'b0;
    repeat (3) @(posedge clk_25_vga);
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        p = make_pixel(mode, x, y);
        r = next_random();
        // Upper nibble of the first byte is junk
        cam_href <= 1'b1;
        cam_d    <= {r[3:0], p[11:8]};
        @(posedge clk_25_vga);
        cam_d <= p[7:0];
        @(posedge clk_25_vga);
      end
      cam_href <= 1'b0;
      cam_d    <= 8'(next_random());
      if (y == H - 1) wait_frame_end();
      // Random idle gap between lines, href low for at least one cycle
      repeat (1 + next_random() % 4) @(posedge clk_25_vga);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    cam_vsync = 1'b0;
    cam_href  = 1'b0;
    cam_d     = 8'h00;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    repeat (16) @(posedge clk_25_vga);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk_25_vga);

    // Reset values, read back, read-only status
    for (int a = 0; a < 6; a++) bus_read(3'(a));
    bus_write(REG_THRESH, next_random());
    bus_read(REG_THRESH);
    bus_write(REG_MIN_COUNT, next_random());
    bus_read(REG_MIN_COUNT);
    bus_write(REG_STATUS, 32'hffff_ffff);
    bus_read(REG_STATUS);
    bus_write(REG_FRAME_COUNT, 32'h0000_5a5a);
    bus_read(REG_FRAME_COUNT);
    restore_defaults();
    det_chk.end_test("register reset and access");

    repeat (2) send_frame(MODE_RANDOM);
    det_chk.end_test("pixel assembly and coordinates");

    repeat (4) begin
      bus_write(REG_THRESH, next_random());
      bus_read(REG_THRESH);
      send_frame(MODE_RANDOM);
    end
    det_chk.end_test("colour rule");

    restore_defaults();
    for (int m = MODE_LEFT; m <= MODE_TIE_ALL; m++) begin
      send_frame(m);
      bus_read(REG_STATUS);
      bus_read(REG_ORANGE_COUNT);
    end
    det_chk.end_test("direction per band");

    // Too few orange pixels then a raised minimum
    send_frame(MODE_SPARSE);
    bus_read(REG_STATUS);
    bus_read(REG_ORANGE_COUNT);
    bus_write(REG_MIN_COUNT, 32'd200);
    send_frame(MODE_LEFT);
    bus_read(REG_STATUS);
    bus_read(REG_ORANGE_COUNT);
    bus_read(REG_FRAME_COUNT);
    det_chk.end_test("detection threshold and frame count");

    end_run(1'b0);
  end

endmodule
